// ==== rtl/entropy_pkg.sv ====
/*
  Shared widths, types and constants for the entropy generator.
  Every RTL file refers to these by scoped name (entropy_pkg::name).
*/
package entropy_pkg;

  // Seed word from software or the entropy network
  typedef logic [31:0] seed_t;

  // Random output word and generator state
  typedef logic [63:0] rand_t;

  // Wait timer limit/value and its prescaler reload
  typedef logic [15:0] timer_t;
  typedef logic [9:0]  prescaler_t;

  // Hash operation count and threshold
  typedef logic [9:0] hash_cnt_t;

  // Seed source selected by software
  typedef enum logic [1:0] {
    ModeNone = 2'h0,
    ModeSw   = 2'h2,
    ModeEdn  = 2'h1
  } entropy_mode_e;

  // Error codes reported to software
  typedef enum logic [7:0] {
    ErrNone             = 8'h00,
    ErrWaitTimerExpired = 8'h04,
    ErrIncorrectMode    = 8'h05
  } err_code_e;

  // Error report, valid for a single cycle
  typedef struct packed {
    logic        valid;
    err_code_e   code;
    logic [23:0] info;
  } err_t;

  // Buffer contents out of reset, handed out as the dummy word
  localparam rand_t ResetRandDefault = 64'h9e37_79b9_7f4a_7c15;

  // Xorshift64 shift amounts
  localparam int unsigned XsShiftA = 13;
  localparam int unsigned XsShiftB = 7;
  localparam int unsigned XsShiftC = 17;

endpackage

// ==== rtl/wait_timer.sv ====
/*
  Prescaled down-counter bounding the wait for network entropy.
  A zero limit disables expiry.
*/
`timescale 1ns/1ns

module wait_timer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    timer_update_i,
  input  logic                    timer_enable_i,
  input  entropy_pkg::timer_t     limit_i,
  input  entropy_pkg::prescaler_t prescaler_i,
  output logic                    expired_o,
  output entropy_pkg::timer_t     value_o
);

  entropy_pkg::prescaler_t presc_reload_q, presc_cnt_q;
  entropy_pkg::timer_t     value_q;
  logic                    nonzero_q, expired_q;
  logic                    tick;

  // Prescaler wrap gives one timer step
  assign tick = timer_enable_i && (presc_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_reload_q <= '0;
      presc_cnt_q    <= '0;
      value_q        <= '0;
      nonzero_q      <= 1'b0;
      expired_q      <= 1'b0;
    end else if (timer_update_i) begin
      presc_reload_q <= prescaler_i;
      presc_cnt_q    <= prescaler_i;
      value_q        <= limit_i;
      nonzero_q      <= |limit_i;
      expired_q      <= 1'b0;
    end else begin
      if (tick) begin
        presc_cnt_q <= presc_reload_q;
      end else if (timer_enable_i) begin
        presc_cnt_q <= presc_cnt_q - 1'b1;
      end
      if (tick && (value_q != '0)) begin
        value_q <= value_q - 1'b1;
      end
      // Only a non-zero limit can run out
      if (timer_enable_i && (value_q == '0) && nonzero_q) begin
        expired_q <= 1'b1;
      end
    end
  end

  assign expired_o = expired_q;
  assign value_o   = value_q;

  // The FSM loads the timer and runs it in separate states
  update_enable_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(timer_update_i && timer_enable_i));

endmodule

// ==== rtl/hash_counter.sv ====
/*
  Counts finished hash operations (falling edges of in_keyblock_i).
  Flags a reseed once a non-zero threshold is reached.
*/
`timescale 1ns/1ns

module hash_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_keyblock_i,
  input  logic                   clr_i,
  input  logic                   refresh_i,
  input  entropy_pkg::hash_cnt_t threshold_i,
  input  logic                   hit_clr_i,
  output entropy_pkg::hash_cnt_t cnt_o,
  output logic                   hit_o
);

  entropy_pkg::hash_cnt_t cnt_q;
  logic                   keyblock_q;
  logic                   hit, hit_q;
  logic                   done;

  // Keyblock phase just ended
  assign done = keyblock_q && !in_keyblock_i;

  assign hit = (threshold_i != '0) && (threshold_i <= cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      keyblock_q <= 1'b0;
      cnt_q      <= '0;
      hit_q      <= 1'b0;
    end else begin
      keyblock_q <= in_keyblock_i;
      // Count restarts after a clear, a refresh or a hit
      if (clr_i || refresh_i || hit) begin
        cnt_q <= '0;
      end else if (done) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Hit held until the FSM starts the reseed
      if (hit_clr_i) begin
        hit_q <= 1'b0;
      end else if (hit) begin
        hit_q <= 1'b1;
      end
    end
  end

  assign cnt_o = cnt_q;
  assign hit_o = hit_q;

endmodule

// ==== rtl/prng_buffer.sv ====
/*
  Xorshift64 generator with its output buffer register.
  Seed load puts the seed in the upper half and its inverse in the lower
  half; each advance steps once and copies the new state to the output.
*/
`timescale 1ns/1ns

module prng_buffer #(
  parameter entropy_pkg::rand_t ResetRand = entropy_pkg::ResetRandDefault
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               seed_load_i,
  input  logic               seed_sel_edn_i,
  input  entropy_pkg::seed_t sw_seed_i,
  input  entropy_pkg::seed_t edn_seed_i,
  input  logic               advance_i,
  output entropy_pkg::rand_t rand_o
);

  entropy_pkg::seed_t seed;
  entropy_pkg::rand_t state_q, state_next, buf_q;

  // One xorshift64 step
  function automatic entropy_pkg::rand_t xs_step(entropy_pkg::rand_t x);
    entropy_pkg::rand_t y;
    y = x ^ (x << entropy_pkg::XsShiftA);
    y = y ^ (y >> entropy_pkg::XsShiftB);
    y = y ^ (y << entropy_pkg::XsShiftC);
    return y;
  endfunction

  // Source follows the latched mode
  assign seed       = seed_sel_edn_i ? edn_seed_i : sw_seed_i;
  assign state_next = xs_step(state_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetRand;
      buf_q   <= ResetRand;
    end else if (seed_load_i) begin
      state_q <= {seed, ~seed};
    end else if (advance_i) begin
      state_q <= state_next;
      // Buffer keeps generator glitches away from the masked core
      buf_q   <= state_next;
    end
  end

  assign rand_o = buf_q;

  load_advance_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(seed_load_i && advance_i));

endmodule

// ==== rtl/entropy_fsm.sv ====
/*
  Control FSM of the entropy generator.
  Seeds the generator from software or the entropy network, keeps the
  valid flag, holds open network requests and reports errors.
*/
`timescale 1ns/1ns

module entropy_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  output logic                       entropy_req_o,
  input  logic                       entropy_ack_i,
  output logic                       rand_valid_o,
  output logic                       rand_early_o,
  input  logic                       rand_update_i,
  input  logic                       rand_consumed_i,
  input  entropy_pkg::entropy_mode_e mode_i,
  input  logic                       entropy_ready_i,
  input  logic                       seed_update_i,
  input  logic                       entropy_refresh_req_i,
  input  logic                       threshold_hit_i,
  output logic                       threshold_hit_clr_o,
  output logic                       timer_update_o,
  output logic                       timer_enable_o,
  input  logic                       timer_expired_i,
  input  entropy_pkg::timer_t        timer_value_i,
  output logic                       seed_load_o,
  output logic                       seed_sel_edn_o,
  output logic                       advance_o,
  output entropy_pkg::err_t          err_o,
  input  logic                       err_processed_i
);

  typedef enum logic [2:0] {
    Reset,
    Edn,
    SwSeedWait,
    Generate,
    Ready,
    ErrWaitExpired,
    ErrIncorrectMode,
    Err
  } state_e;

  state_e state_q, state_d;

  // Mode is latched when leaving Reset
  entropy_pkg::entropy_mode_e mode_q;
  logic                       mode_latch;

  // Valid flag: direct set, delayed set via the early flag, clear
  logic valid_set, valid_clear, gen_set;
  logic valid_q, early_q;

  // Seed load of the previous cycle, tells Generate to step the generator
  logic seeded_q;

  // Network request and its hold until acknowledged
  logic entropy_req;
  logic req_hold_q;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Reset;
      mode_q     <= entropy_pkg::ModeNone;
      valid_q    <= 1'b0;
      early_q    <= 1'b0;
      seeded_q   <= 1'b0;
      req_hold_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      early_q  <= gen_set;
      seeded_q <= seed_load_o;
      // Request stays up until an acknowledge is seen
      req_hold_q <= (req_hold_q | entropy_req) & ~entropy_ack_i;
      if (mode_latch) begin
        mode_q <= mode_i;
      end
      // Set wins over clear
      if (valid_set || early_q) begin
        valid_q <= 1'b1;
      end else if (valid_clear) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign rand_valid_o   = valid_q;
  // One cycle warning ahead of valid after a fresh word
  assign rand_early_o   = early_q;
  assign entropy_req_o  = entropy_req | req_hold_q;
  assign seed_sel_edn_o = (mode_q == entropy_pkg::ModeEdn);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d             = state_q;
    mode_latch          = 1'b0;
    valid_set           = 1'b0;
    valid_clear         = 1'b0;
    gen_set             = 1'b0;
    entropy_req         = 1'b0;
    timer_update_o      = 1'b0;
    timer_enable_o      = 1'b0;
    threshold_hit_clr_o = 1'b0;
    seed_load_o         = 1'b0;
    advance_o           = 1'b0;
    err_o               = '{valid: 1'b0, code: entropy_pkg::ErrNone, info: '0};

    unique case (state_q)
      Reset: begin
        if (entropy_ready_i) begin
          // Drop the dummy word and pick up the configured mode
          valid_clear = 1'b1;
          mode_latch  = 1'b1;
          if (mode_i == entropy_pkg::ModeSw) begin
            state_d = SwSeedWait;
          end else if (mode_i == entropy_pkg::ModeEdn) begin
            timer_update_o = 1'b1;
            state_d        = Edn;
          end else begin
            state_d = ErrIncorrectMode;
          end
        end else begin
          // Dummy word lets consumers run before software sets up
          valid_set = 1'b1;
        end
      end

      SwSeedWait: begin
        if (seed_update_i) begin
          seed_load_o = 1'b1;
          state_d     = Generate;
        end
      end

      Edn: begin
        entropy_req    = 1'b1;
        timer_enable_o = 1'b1;
        if (timer_expired_i) begin
          state_d = ErrWaitExpired;
        end else if (entropy_ack_i) begin
          // Network seed taken in the acknowledge cycle
          seed_load_o = 1'b1;
          valid_clear = 1'b1;
          state_d     = Generate;
        end else if (rand_update_i || rand_consumed_i) begin
          // Old word still in use while the reseed is pending
          advance_o   = 1'b1;
          valid_clear = rand_consumed_i;
        end
      end

      Generate: begin
        // Step past the raw seed, valid follows one cycle after early
        advance_o = seeded_q;
        gen_set   = 1'b1;
        state_d   = Ready;
      end

      Ready: begin
        if (rand_update_i || rand_consumed_i) begin
          advance_o = 1'b1;
          if (rand_consumed_i) begin
            valid_clear = 1'b1;
            state_d     = Generate;
          end
        end else if ((mode_q == entropy_pkg::ModeEdn) &&
                     (entropy_refresh_req_i || threshold_hit_i)) begin
          timer_update_o      = 1'b1;
          threshold_hit_clr_o = 1'b1;
          state_d             = Edn;
        end
      end

      ErrWaitExpired: begin
        err_o = '{valid: 1'b1, code: entropy_pkg::ErrWaitTimerExpired,
                  info: 24'(timer_value_i)};
        state_d = Err;
      end

      ErrIncorrectMode: begin
        err_o = '{valid: 1'b1, code: entropy_pkg::ErrIncorrectMode,
                  info: 24'(mode_q)};
        state_d = Err;
      end

      Err: begin
        // Keep the current hash going, still step on every use
        valid_set = 1'b1;
        advance_o = rand_update_i | rand_consumed_i;
        if (err_processed_i) begin
          state_d = Reset;
        end
      end

      default: begin
        state_d = Reset;
      end
    endcase
  end

  // Consumers use the word only while valid, or right after a reseed
  consume_when_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rand_update_i || rand_consumed_i) |-> (rand_valid_o || $past(seed_load_o)));

endmodule

// ==== rtl/entropy_top.sv ====
/*
  Entropy generator top level for the masked hashing core.
  Connects the control FSM, the network wait timer, the hash operation
  counter and the xorshift generator with its output buffer.
*/
`timescale 1ns/1ns

module entropy_top #(
  parameter entropy_pkg::rand_t ResetRand = entropy_pkg::ResetRandDefault
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Entropy network link
  output logic                       entropy_req_o,
  input  logic                       entropy_ack_i,
  input  entropy_pkg::seed_t         entropy_data_i,
  // Consumer link
  output logic                       rand_valid_o,
  output logic                       rand_early_o,
  output entropy_pkg::rand_t         rand_data_o,
  input  logic                       rand_update_i,
  input  logic                       rand_consumed_i,
  // Status and configuration
  input  logic                       in_keyblock_i,
  input  entropy_pkg::entropy_mode_e mode_i,
  input  logic                       entropy_ready_i,
  input  logic                       seed_update_i,
  input  entropy_pkg::seed_t         seed_data_i,
  input  logic                       entropy_refresh_req_i,
  input  entropy_pkg::prescaler_t    wait_timer_prescaler_i,
  input  entropy_pkg::timer_t        wait_timer_limit_i,
  // Hash operation counter
  output entropy_pkg::hash_cnt_t     hash_cnt_o,
  input  logic                       hash_cnt_clr_i,
  input  entropy_pkg::hash_cnt_t     hash_threshold_i,
  // Error report
  output entropy_pkg::err_t          err_o,
  input  logic                       err_processed_i
);

  // FSM to timer
  logic                timer_update;
  logic                timer_enable;
  logic                timer_expired;
  entropy_pkg::timer_t timer_value;

  // FSM to hash counter
  logic threshold_hit;
  logic threshold_hit_clr;

  // FSM to generator
  logic seed_load;
  logic seed_sel_edn;
  logic advance;

  entropy_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .entropy_req_o,
    .entropy_ack_i,
    .rand_valid_o,
    .rand_early_o,
    .rand_update_i,
    .rand_consumed_i,
    .mode_i,
    .entropy_ready_i,
    .seed_update_i,
    .entropy_refresh_req_i,
    .threshold_hit_i     (threshold_hit),
    .threshold_hit_clr_o (threshold_hit_clr),
    .timer_update_o      (timer_update),
    .timer_enable_o      (timer_enable),
    .timer_expired_i     (timer_expired),
    .timer_value_i       (timer_value),
    .seed_load_o         (seed_load),
    .seed_sel_edn_o      (seed_sel_edn),
    .advance_o           (advance),
    .err_o,
    .err_processed_i
  );

  wait_timer u_wait_timer (
    .clk_i,
    .rst_ni,
    .timer_update_i (timer_update),
    .timer_enable_i (timer_enable),
    .limit_i        (wait_timer_limit_i),
    .prescaler_i    (wait_timer_prescaler_i),
    .expired_o      (timer_expired),
    .value_o        (timer_value)
  );

  hash_counter u_hash_counter (
    .clk_i,
    .rst_ni,
    .in_keyblock_i,
    .clr_i       (hash_cnt_clr_i),
    .refresh_i   (entropy_refresh_req_i),
    .threshold_i (hash_threshold_i),
    .hit_clr_i   (threshold_hit_clr),
    .cnt_o       (hash_cnt_o),
    .hit_o       (threshold_hit)
  );

  prng_buffer #(
    .ResetRand (ResetRand)
  ) u_prng_buffer (
    .clk_i,
    .rst_ni,
    .seed_load_i    (seed_load),
    .seed_sel_edn_i (seed_sel_edn),
    .sw_seed_i      (seed_data_i),
    .edn_seed_i     (entropy_data_i),
    .advance_i      (advance),
    .rand_o         (rand_data_o)
  );

endmodule

// ==== tb/tb_entropy.sv ====
/*
  Self-checking testbench for entropy_top.
  Reads operations from tb/entropy_cases.txt, drives them on the falling
  edge and checks the outputs against its own xorshift model.
*/
`timescale 1ns/1ns

module tb_entropy;

  localparam int unsigned ClkHalf       = 20;
  localparam int unsigned PerCaseCycles = 120;
  localparam entropy_pkg::hash_cnt_t  Threshold = 10'd4;
  localparam entropy_pkg::prescaler_t Prescale  = 10'd2;
  // Xorshift shift amounts of the generator
  localparam int unsigned ShA = 13;
  localparam int unsigned ShB = 7;
  localparam int unsigned ShC = 17;

  logic                       clk_i, rst_ni;
  logic                       entropy_req_o, entropy_ack_i;
  entropy_pkg::seed_t         entropy_data_i, seed_data_i;
  logic                       rand_valid_o, rand_early_o;
  entropy_pkg::rand_t         rand_data_o;
  logic                       rand_update_i, rand_consumed_i;
  logic                       in_keyblock_i, entropy_ready_i;
  logic                       seed_update_i, entropy_refresh_req_i;
  entropy_pkg::entropy_mode_e mode_i;
  entropy_pkg::prescaler_t    wait_timer_prescaler_i;
  entropy_pkg::timer_t        wait_timer_limit_i;
  entropy_pkg::hash_cnt_t     hash_cnt_o, hash_threshold_i;
  logic                       hash_cnt_clr_i, err_processed_i;
  entropy_pkg::err_t          err_o;

  // Case table
  logic [63:0] op_q[$];
  logic [63:0] arg_q[$];
  logic [63:0] exp_q[$];

  int unsigned        error_cnt, check_cnt, cycle_cnt, cycle_limit;
  int unsigned        hash_model;
  entropy_pkg::rand_t model_state;
  logic               configured;
  string              case_name;

  entropy_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #ClkHalf clk_i = ~clk_i;
  end

  // Watchdog over the whole run
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: no progress within %0d cycles, %0d errors so far",
               cycle_limit, error_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Model and checks
  ////////////////////

  function automatic entropy_pkg::rand_t next_word(input entropy_pkg::rand_t s);
    entropy_pkg::rand_t t;
    t = s ^ (s << ShA);
    t = t ^ (t >> ShB);
    return t ^ (t << ShC);
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    check_cnt++;
    assert (exp === act) else begin
      $display("Fail %s %s: expected %h, actual %h", case_name, what, exp, act);
      error_cnt++;
    end
  endtask

  // Counts edges until valid is back and checks that early leads by one cycle
  task automatic wait_valid(input logic [63:0] exp_lat);
    int unsigned lat;
    logic        early_before;
    lat = 0;
    early_before = 1'b0;
    while (!rand_valid_o) begin
      early_before = rand_early_o;
      @(negedge clk_i);
      lat++;
    end
    check_value("valid latency", exp_lat, 64'(lat));
    check_value("early flag", 64'd1, 64'(early_before));
    check_value("word", model_state, rand_data_o);
  endtask

  task automatic init_inputs;
    rst_ni                 = 1'b0;
    entropy_ack_i          = 1'b0;
    entropy_data_i         = '0;
    rand_update_i          = 1'b0;
    rand_consumed_i        = 1'b0;
    in_keyblock_i          = 1'b0;
    mode_i                 = entropy_pkg::ModeNone;
    entropy_ready_i        = 1'b0;
    seed_update_i          = 1'b0;
    seed_data_i            = '0;
    entropy_refresh_req_i  = 1'b0;
    wait_timer_prescaler_i = Prescale;
    wait_timer_limit_i     = '0;
    hash_cnt_clr_i         = 1'b0;
    hash_threshold_i       = Threshold;
    err_processed_i        = 1'b0;
  endtask

  ////////////////////
  // Operations
  ////////////////////

  task automatic apply_reset(input logic [63:0] exp);
    init_inputs();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("valid out of reset", 64'd0, 64'(rand_valid_o));
    check_value("request out of reset", 64'd0, 64'(entropy_req_o));
    check_value("error out of reset", 64'd0, 64'(err_o.valid));
    @(negedge clk_i);
    // Dummy word follows one cycle later
    check_value("dummy valid", 64'd1, 64'(rand_valid_o));
    check_value("dummy word", exp, rand_data_o);
    model_state = exp;
    hash_model  = 0;
    configured  = 1'b0;
  endtask

  task automatic seed_from_sw(input logic [63:0] arg, input logic [63:0] exp);
    mode_i          = entropy_pkg::ModeSw;
    entropy_ready_i = 1'b1;
    @(negedge clk_i);
    configured = 1'b1;
    check_value("dummy dropped", 64'd0, 64'(rand_valid_o));
    seed_update_i = 1'b1;
    seed_data_i   = arg[31:0];
    @(negedge clk_i);
    seed_update_i = 1'b0;
    model_state   = next_word({arg[31:0], ~arg[31:0]});
    wait_valid(exp);
  endtask

  // Leaves Reset in network mode or asks for a refresh once running
  task automatic start_request(input entropy_pkg::timer_t limit);
    wait_timer_limit_i = limit;
    if (!configured) begin
      mode_i          = entropy_pkg::ModeEdn;
      entropy_ready_i = 1'b1;
      @(negedge clk_i);
      configured = 1'b1;
    end else begin
      entropy_refresh_req_i = 1'b1;
      @(negedge clk_i);
      entropy_refresh_req_i = 1'b0;
      hash_model = 0;
    end
  endtask

  task automatic seed_from_network(input logic [63:0] arg, input logic [63:0] exp);
    int unsigned delay;
    // A request may already be open after a threshold hit
    if (!entropy_req_o) begin
      start_request('0);
    end
    while (!entropy_req_o) @(negedge clk_i);
    delay = $urandom % 6;
    repeat (delay) begin
      check_value("request held", 64'd1, 64'(entropy_req_o));
      @(negedge clk_i);
    end
    entropy_ack_i  = 1'b1;
    entropy_data_i = arg[31:0];
    @(negedge clk_i);
    entropy_ack_i = 1'b0;
    check_value("request dropped", 64'd0, 64'(entropy_req_o));
    model_state = next_word({arg[31:0], ~arg[31:0]});
    wait_valid(exp);
  endtask

  task automatic consume_words(input logic [63:0] arg, input logic [63:0] exp);
    repeat (arg) begin
      rand_consumed_i = 1'b1;
      @(negedge clk_i);
      rand_consumed_i = 1'b0;
      model_state     = next_word(model_state);
      wait_valid(exp);
    end
  endtask

  task automatic update_words(input logic [63:0] arg, input logic [63:0] exp);
    repeat (arg) begin
      rand_update_i = 1'b1;
      @(negedge clk_i);
      rand_update_i = 1'b0;
      model_state   = next_word(model_state);
      check_value("valid kept", exp, 64'(rand_valid_o));
      check_value("updated word", model_state, rand_data_o);
    end
  endtask

  task automatic pulse_keyblocks(input logic [63:0] arg, input logic [63:0] exp);
    repeat (arg) begin
      in_keyblock_i = 1'b1;
      @(negedge clk_i);
      in_keyblock_i = 1'b0;
      @(negedge clk_i);
      hash_model++;
      check_value("hash count", 64'(hash_model), 64'(hash_cnt_o));
      if (hash_model == Threshold) begin
        // Hit clears the count and starts a reseed
        @(negedge clk_i);
        hash_model = 0;
        check_value("count cleared", 64'd0, 64'(hash_cnt_o));
        while (!entropy_req_o) @(negedge clk_i);
      end
    end
    check_value("final hash count", exp, 64'(hash_cnt_o));
  endtask

  task automatic recover_from_error;
    entropy_ready_i = 1'b0;
    err_processed_i = 1'b1;
    @(negedge clk_i);
    err_processed_i = 1'b0;
    @(negedge clk_i);
    check_value("valid after recovery", 64'd1, 64'(rand_valid_o));
    check_value("word after recovery", model_state, rand_data_o);
    check_value("error after recovery", 64'd0, 64'(err_o.valid));
    configured = 1'b0;
  endtask

  task automatic expect_timeout(input logic [63:0] arg, input logic [63:0] exp);
    start_request(arg[15:0]);
    while (!err_o.valid) @(negedge clk_i);
    check_value("error code", exp, 64'(err_o.code));
    check_value("error info", 64'd0, 64'(err_o.info));
    @(negedge clk_i);
    check_value("error one cycle", 64'd0, 64'(err_o.valid));
    check_value("request held after expiry", 64'd1, 64'(entropy_req_o));
    // Late acknowledge closes the request and its data is dropped
    entropy_ack_i  = 1'b1;
    entropy_data_i = 32'hdead_beef;
    @(negedge clk_i);
    entropy_ack_i = 1'b0;
    check_value("late request closed", 64'd0, 64'(entropy_req_o));
    // Update in the error state still steps the old generator state
    rand_update_i = 1'b1;
    @(negedge clk_i);
    rand_update_i = 1'b0;
    model_state   = next_word(model_state);
    check_value("valid in error state", 64'd1, 64'(rand_valid_o));
    check_value("word in error state", model_state, rand_data_o);
    wait_timer_limit_i = '0;
    recover_from_error();
  endtask

  task automatic expect_bad_mode(input logic [63:0] arg, input logic [63:0] exp);
    mode_i          = entropy_pkg::entropy_mode_e'(arg[1:0]);
    entropy_ready_i = 1'b1;
    @(negedge clk_i);
    configured = 1'b1;
    check_value("error valid", 64'd1, 64'(err_o.valid));
    check_value("error code", exp, 64'(err_o.code));
    check_value("error info", 64'(arg[1:0]), 64'(err_o.info));
    @(negedge clk_i);
    check_value("error one cycle", 64'd0, 64'(err_o.valid));
    recover_from_error();
    mode_i = entropy_pkg::ModeNone;
  endtask

  ////////////////////
  // Case file and run
  ////////////////////

  task automatic load_cases(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [63:0] name, arg, exp;
    ok = 1'b0;
    fd = $fopen("tb/entropy_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Skip blank and comment lines
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h", name, arg, exp);
          if (n == 3) begin
            op_q.push_back(name);
            arg_q.push_back(arg);
            exp_q.push_back(exp);
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  task automatic run_cases;
    for (int i = 0; i < op_q.size(); i++) begin
      case_name = $sformatf("case %0d %0s", i, op_q[i]);
      case (op_q[i])
        "reset":    apply_reset(exp_q[i]);
        "swseed":   seed_from_sw(arg_q[i], exp_q[i]);
        "ednseed":  seed_from_network(arg_q[i], exp_q[i]);
        "consume":  consume_words(arg_q[i], exp_q[i]);
        "update":   update_words(arg_q[i], exp_q[i]);
        "keyblock": pulse_keyblocks(arg_q[i], exp_q[i]);
        "timeout":  expect_timeout(arg_q[i], exp_q[i]);
        "badmode":  expect_bad_mode(arg_q[i], exp_q[i]);
        default: begin
          $display("Unknown operation in %s", case_name);
          error_cnt++;
        end
      endcase
    end
  endtask

  initial begin
    logic ok;
    init_inputs();
    error_cnt   = 0;
    check_cnt   = 0;
    cycle_cnt   = 0;
    cycle_limit = PerCaseCycles;
    hash_model  = 0;
    configured  = 1'b0;
    model_state = '0;
    case_name   = "setup";
    void'($urandom(32'hbb5b));
    load_cases(ok);
    if (!ok) begin
      $display("No cases could be read from tb/entropy_cases.txt");
      $display("Checks failed");
      $finish;
    end else begin
      cycle_limit = op_q.size() * PerCaseCycles;
      run_cases();
      $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

// ==== tb.f ====
rtl/entropy_pkg.sv
rtl/wait_timer.sv
rtl/hash_counter.sv
rtl/prng_buffer.sv
rtl/entropy_fsm.sv
rtl/entropy_top.sv
tb/tb_entropy.sv

// ==== Makefile ====
# Verilator build and run for the entropy generator testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_entropy
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/entropy_cases.txt ====
# Columns: operation, operand (hex), expected value (hex)
# Expected is the reset word, the valid latency, valid level, hash count or error code
reset     0         9e3779b97f4a7c15
badmode   3         5
reset     0         9e3779b97f4a7c15
swseed    1234abcd  2
consume   3         2
update    2         1
consume   1         2
reset     0         9e3779b97f4a7c15
ednseed   0badc0de  2
consume   2         2
update    1         1
keyblock  3         3
keyblock  1         0
ednseed   5eed5eed  2
consume   1         2
ednseed   c0ffee11  2
timeout   6         4
swseed    600dcafe  2
consume   2         2
reset     0         9e3779b97f4a7c15
timeout   3         4
badmode   0         5
ednseed   13579bdf  2
update    3         1
consume   1         2
keyblock  2         2
